// ==== common/light_game_pkg.sv ====
`default_nettype none

package light_game_pkg;

    // board size, one switch per LED
    localparam int NUM_LEDS = 16;

    // length of the step table
    localparam int NUM_STEPS = 50;

    // wide enough to hold NUM_STEPS itself, which marks the end of the game
    localparam int STEP_W = 6;

    // one bit per LED or switch
    typedef logic [NUM_LEDS-1:0] led_t;

    // step index, 0 to NUM_STEPS
    typedef logic [STEP_W-1:0] step_t;

    // single BCD digit of the score
    typedef logic [3:0] bcd_digit_t;

    // one table step. level 1 lights the LED and level 0 puts it out
    typedef struct packed {
        logic [$clog2(NUM_LEDS)-1:0] idx;
        logic                        level;
    } step_entry_t;

endpackage

`default_nettype wire

// ==== light_game/light_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module light_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clk_1sec,
    input  logic                  time_up,
    input  light_game_pkg::led_t  switches,
    output light_game_pkg::led_t  led,
    output logic                  catch
);

    import light_game_pkg::*;

    step_t       step_q;
    led_t        caught_q;
    logic        finished_q;
    step_entry_t entry;
    led_t        target;
    logic        game_over;

    step_table u_step_table (
        .step  (step_q),
        .entry (entry)
    );

    // target is the caught pattern with this step's single LED change
    always_comb
    begin
        target = caught_q;
        target[entry.idx] = entry.level;
    end

    assign game_over = finished_q | time_up;

    // a catch needs active play and an exact match on all switches
    assign catch = ~game_over && (switches == target);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            step_q     <= '0;
            caught_q   <= '0;
            finished_q <= 1'b0;
        end
        else if (catch)
        begin
            caught_q <= target;
            step_q   <= step_q + step_t'(1);
            // the last catch moves the step to NUM_STEPS and ends the game
            if (step_q == step_t'(NUM_STEPS - 1))
            begin
                finished_q <= 1'b1;
            end
        end
    end

    // blink while the game is over, all on during the low half of clk_1sec
    always_comb
    begin
        if (game_over)
        begin
            led = {NUM_LEDS{~clk_1sec}};
        end
        else
        begin
            led = target;
        end
    end

endmodule

`default_nettype wire

// ==== light_game/step_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_table (
    input  light_game_pkg::step_t       step,
    output light_game_pkg::step_entry_t entry
);

    // pure lookup with no state. Each entry gives the LED changed on that step
    always_comb
    begin
        case (step)
            6'd0:    entry = '{idx: 4'd2,  level: 1'b1};
            6'd1:    entry = '{idx: 4'd5,  level: 1'b1};
            6'd2:    entry = '{idx: 4'd8,  level: 1'b1};
            6'd3:    entry = '{idx: 4'd11, level: 1'b1};
            6'd4:    entry = '{idx: 4'd1,  level: 1'b1};
            6'd5:    entry = '{idx: 4'd3,  level: 1'b1};
            6'd6:    entry = '{idx: 4'd7,  level: 1'b1};
            6'd7:    entry = '{idx: 4'd9,  level: 1'b1};
            6'd8:    entry = '{idx: 4'd5,  level: 1'b0};
            6'd9:    entry = '{idx: 4'd11, level: 1'b0};
            6'd10:   entry = '{idx: 4'd1,  level: 1'b0};
            6'd11:   entry = '{idx: 4'd0,  level: 1'b1};
            6'd12:   entry = '{idx: 4'd4,  level: 1'b1};
            6'd13:   entry = '{idx: 4'd13, level: 1'b1};
            6'd14:   entry = '{idx: 4'd6,  level: 1'b1};
            6'd15:   entry = '{idx: 4'd8,  level: 1'b0};
            6'd16:   entry = '{idx: 4'd10, level: 1'b1};
            6'd17:   entry = '{idx: 4'd12, level: 1'b1};
            6'd18:   entry = '{idx: 4'd3,  level: 1'b0};
            6'd19:   entry = '{idx: 4'd15, level: 1'b1};
            6'd20:   entry = '{idx: 4'd7,  level: 1'b0};
            6'd21:   entry = '{idx: 4'd14, level: 1'b1};
            6'd22:   entry = '{idx: 4'd7,  level: 1'b1};
            6'd23:   entry = '{idx: 4'd4,  level: 1'b0};
            6'd24:   entry = '{idx: 4'd14, level: 1'b0};
            6'd25:   entry = '{idx: 4'd5,  level: 1'b1};
            6'd26:   entry = '{idx: 4'd1,  level: 1'b1};
            6'd27:   entry = '{idx: 4'd0,  level: 1'b0};
            6'd28:   entry = '{idx: 4'd10, level: 1'b0};
            6'd29:   entry = '{idx: 4'd9,  level: 1'b0};
            6'd30:   entry = '{idx: 4'd3,  level: 1'b1};
            6'd31:   entry = '{idx: 4'd1,  level: 1'b0};
            6'd32:   entry = '{idx: 4'd15, level: 1'b0};
            6'd33:   entry = '{idx: 4'd14, level: 1'b1};
            6'd34:   entry = '{idx: 4'd8,  level: 1'b1};
            6'd35:   entry = '{idx: 4'd2,  level: 1'b0};
            6'd36:   entry = '{idx: 4'd6,  level: 1'b0};
            6'd37:   entry = '{idx: 4'd0,  level: 1'b1};
            6'd38:   entry = '{idx: 4'd15, level: 1'b1};
            6'd39:   entry = '{idx: 4'd1,  level: 1'b1};
            6'd40:   entry = '{idx: 4'd14, level: 1'b0};
            6'd41:   entry = '{idx: 4'd2,  level: 1'b1};
            6'd42:   entry = '{idx: 4'd6,  level: 1'b1};
            6'd43:   entry = '{idx: 4'd5,  level: 1'b0};
            6'd44:   entry = '{idx: 4'd3,  level: 1'b0};
            6'd45:   entry = '{idx: 4'd7,  level: 1'b0};
            6'd46:   entry = '{idx: 4'd9,  level: 1'b1};
            6'd47:   entry = '{idx: 4'd11, level: 1'b1};
            6'd48:   entry = '{idx: 4'd13, level: 1'b0};
            6'd49:   entry = '{idx: 4'd6,  level: 1'b0};
            // past the last step the game is finished and the target is not shown
            default: entry = '{idx: 4'd0,  level: 1'b0};
        endcase
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/light_game_pkg.sv
light_game/step_table.sv
light_game/light_sequencer.sv
verilog/bcd_score_counter.sv
verilog/catch_the_light.sv
testbench/catch_the_light_checker.sv
testbench/tb_catch_the_light.sv

// ==== testbench/catch_the_light_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module catch_the_light_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        time_up,
    input  light_game_pkg::led_t        led,
    input  light_game_pkg::bcd_digit_t  score_ones,
    input  light_game_pkg::bcd_digit_t  score_tens
);

    import light_game_pkg::*;

    // read by the testbench at the end of the run
    int assert_failures = 0;

    logic [7:0] score;

    // packed BCD compares in the same order as the decimal value
    assign score = {score_tens, score_ones};

    digits_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (score_ones <= 4'd9) && (score_tens <= 4'd9))
    else
    begin
        $error("score digit above 9");
        assert_failures++;
    end

    score_frozen_on_time_up: assert property (
        @(posedge clk) disable iff (rst)
        time_up |=> $stable(score))
    else
    begin
        $error("score changed while time_up was high");
        assert_failures++;
    end

    blink_on_time_up: assert property (
        @(posedge clk) disable iff (rst)
        time_up |-> ((led == {NUM_LEDS{1'b1}}) || (led == {NUM_LEDS{1'b0}})))
    else
    begin
        $error("led not a blink pattern while time_up was high");
        assert_failures++;
    end

    score_monotonic: assert property (
        @(posedge clk) disable iff (rst)
        score >= $past(score))
    else
    begin
        $error("score decreased outside reset");
        assert_failures++;
    end

endmodule

bind catch_the_light catch_the_light_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .time_up    (time_up),
    .led        (led),
    .score_ones (score_ones),
    .score_tens (score_tens)
);

`default_nettype wire

// ==== testbench/light_game_cases.txt ====
// columns, all hex: switches time_up clk_1sec led score_tens score_ones
// a switches value of 10000 asks for a random value that differs from led
// reset state, wrong switches hold step 0
10000 0 0 0004 0 0
10000 0 1 0004 0 0
0000 0 0 0004 0 0
0006 0 0 0004 0 0
0005 0 1 0004 0 0
10000 0 0 0004 0 0
// catch steps 0 to 12, carry from 09 to 10
0004 0 0 0004 0 0
0024 0 0 0024 0 1
0124 0 1 0124 0 2
0924 0 0 0924 0 3
0926 0 0 0926 0 4
092e 0 0 092e 0 5
09ae 0 1 09ae 0 6
0bae 0 0 0bae 0 7
0b8e 0 0 0b8e 0 8
038e 0 0 038e 0 9
038c 0 0 038c 1 0
038d 0 0 038d 1 1
039d 0 0 039d 1 2
// one bit off at step 13
239c 0 0 239d 1 3
// time_up blinks and freezes the score even with matching switches
239d 1 0 ffff 1 3
239d 1 1 0000 1 3
239d 1 0 ffff 1 3
10000 1 1 0000 1 3
ffff 1 0 ffff 1 3
// play resumes at step 13, carry from 19 to 20
239d 0 1 239d 1 3
23dd 0 0 23dd 1 4
22dd 0 0 22dd 1 5
26dd 0 0 26dd 1 6
36dd 0 0 36dd 1 7
36d5 0 0 36d5 1 8
b6d5 0 0 b6d5 1 9
b655 0 0 b655 2 0
f655 0 0 f655 2 1
f6d5 0 1 f6d5 2 2
f6c5 0 0 f6c5 2 3
b6c5 0 0 b6c5 2 4
b6e5 0 0 b6e5 2 5
b6e7 0 0 b6e7 2 6
b6e6 0 0 b6e6 2 7
b2e6 0 0 b2e6 2 8
b0e6 0 0 b0e6 2 9
b0ee 0 0 b0ee 3 0
b0ec 0 0 b0ec 3 1
30ec 0 0 30ec 3 2
70ec 0 1 70ec 3 3
71ec 0 0 71ec 3 4
71e8 0 0 71e8 3 5
71a8 0 0 71a8 3 6
71a9 0 0 71a9 3 7
f1a9 0 0 f1a9 3 8
f1ab 0 0 f1ab 3 9
b1ab 0 0 b1ab 4 0
b1af 0 0 b1af 4 1
b1ef 0 0 b1ef 4 2
b1cf 0 0 b1cf 4 3
b1c7 0 1 b1c7 4 4
b147 0 0 b147 4 5
b347 0 0 b347 4 6
bb47 0 0 bb47 4 7
9b47 0 0 9b47 4 8
9b07 0 0 9b07 4 9
// finished, blinking from here on and nothing else changes
9b07 0 0 ffff 5 0
9b07 0 1 0000 5 0
ffff 0 0 ffff 5 0
0000 0 1 0000 5 0
9b07 1 0 ffff 5 0
10000 1 1 0000 5 0
10000 0 0 ffff 5 0
9b07 0 1 0000 5 0

// ==== testbench/tb_catch_the_light.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_catch_the_light;

    import light_game_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    // outputs are sampled this long before the next rising edge
    localparam int SAMPLE_AHEAD = 5;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CASES    = 96;
    localparam int FIELDS       = 6;

    localparam logic [19:0] RANDOM_SWITCHES = 20'h10000;
    localparam logic [3:0]  UNUSED_TAG      = 4'hf;

    logic       clk;
    logic       rst;
    logic       clk_1sec;
    logic       time_up;
    led_t       switches;
    led_t       led;
    bcd_digit_t score_ones;
    bcd_digit_t score_tens;

    logic [19:0] case_mem [0:MAX_CASES*FIELDS-1];
    int          num_cases;
    int          case_index;
    int          check_errors;
    logic        cases_loaded;
    integer      seed;

    catch_the_light DUT (
        .clk        (clk),
        .rst        (rst),
        .clk_1sec   (clk_1sec),
        .time_up    (time_up),
        .switches   (switches),
        .led        (led),
        .score_ones (score_ones),
        .score_tens (score_tens)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // unread words carry a tag nibble over their own address, so the vectors can be counted
    task automatic load_cases();
        int words;
        for (int k = 0; k < MAX_CASES * FIELDS; k++)
        begin
            case_mem[k] = {UNUSED_TAG, 16'(k)};
        end
        $readmemh("testbench/light_game_cases.txt", case_mem);
        words = 0;
        while ((words < MAX_CASES * FIELDS) && (case_mem[words][19:16] != UNUSED_TAG))
        begin
            words++;
        end
        if ((words % FIELDS) != 0)
        begin
            $display("case file has %0d words, not a whole number of vectors", words);
            check_errors++;
        end
        num_cases = words / FIELDS;
    endtask

    task automatic draw_mismatch(input led_t avoid, output led_t value);
        value = led_t'($random(seed));
        while (value == avoid)
        begin
            value = led_t'($random(seed));
        end
    endtask

    task automatic compare_value(
        input string       name,
        input logic [15:0] expected,
        input logic [15:0] actual
    );
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED at %0d ns, case %0d: %s expected %h, got %h",
                     $time, case_index, name, expected, actual);
            check_errors++;
        end
    endtask

    // drives one vector and hands back what the outputs should show
    task automatic apply_case(
        input  int         index,
        output led_t       exp_led,
        output bcd_digit_t exp_tens,
        output bcd_digit_t exp_ones
    );
        logic [19:0] sw_word;
        led_t        filler;
        sw_word  = case_mem[index*FIELDS + 0];
        exp_led  = led_t'(case_mem[index*FIELDS + 3]);
        exp_tens = bcd_digit_t'(case_mem[index*FIELDS + 4]);
        exp_ones = bcd_digit_t'(case_mem[index*FIELDS + 5]);
        if (sw_word == RANDOM_SWITCHES)
        begin
            draw_mismatch(exp_led, filler);
            switches = filler;
        end
        else
        begin
            switches = led_t'(sw_word);
        end
        time_up  = case_mem[index*FIELDS + 1][0];
        clk_1sec = case_mem[index*FIELDS + 2][0];
    endtask

    initial
    begin
        wait (cases_loaded === 1'b1);
        #((RESET_CYCLES + num_cases + 20) * CLK_PERIOD);
        $display("watchdog expired at %0d ns, the case sequence did not complete", $time);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        led_t       exp_led;
        bcd_digit_t exp_tens;
        bcd_digit_t exp_ones;
        int         assert_errors;

        rst          = 1'b1;
        clk_1sec     = 1'b0;
        time_up      = 1'b0;
        switches     = '0;
        seed         = 32'h156c;
        check_errors = 0;
        case_index   = 0;
        num_cases    = 0;
        cases_loaded = 1'b0;

        load_cases();
        cases_loaded = 1'b1;
        if (num_cases == 0)
        begin
            $display("no test vectors read from testbench/light_game_cases.txt");
            check_errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        for (int i = 0; i < num_cases; i++)
        begin
            case_index = i;
            apply_case(i, exp_led, exp_tens, exp_ones);
            #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_AHEAD);
            compare_value("led", exp_led, led);
            compare_value("score_tens", 16'(exp_tens), 16'(score_tens));
            compare_value("score_ones", 16'(exp_ones), 16'(score_ones));
            @(posedge clk);
            #DRIVE_DELAY;
        end

        assert_errors = DUT.u_checker.assert_failures;
        $display("cases run: %0d, check errors: %0d, assertion errors: %0d",
                 num_cases, check_errors, assert_errors);
        if ((check_errors == 0) && (assert_errors == 0))
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/bcd_score_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bcd_score_counter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        catch,
    output light_game_pkg::bcd_digit_t  score_ones,
    output light_game_pkg::bcd_digit_t  score_tens
);

    logic ones_wrap;

    // ones digit rolls over on this catch
    assign ones_wrap = catch && (score_ones == 4'd9);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            score_ones <= 4'd0;
        end
        else if (catch)
        begin
            if (ones_wrap)
            begin
                score_ones <= 4'd0;
            end
            else
            begin
                score_ones <= score_ones + 4'd1;
            end
        end
    end

    // at most 50 catches reach here, so tens never passes 5
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            score_tens <= 4'd0;
        end
        else if (ones_wrap)
        begin
            score_tens <= score_tens + 4'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/catch_the_light.sv ====
`timescale 1ns/1ps
`default_nettype none

module catch_the_light (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clk_1sec,
    input  logic                        time_up,
    input  light_game_pkg::led_t        switches,
    output light_game_pkg::led_t        led,
    output light_game_pkg::bcd_digit_t  score_ones,
    output light_game_pkg::bcd_digit_t  score_tens
);

    // one-cycle strobe per caught step
    logic catch;

    light_sequencer u_light_sequencer (
        .clk      (clk),
        .rst      (rst),
        .clk_1sec (clk_1sec),
        .time_up  (time_up),
        .switches (switches),
        .led      (led),
        .catch    (catch)
    );

    bcd_score_counter u_bcd_score_counter (
        .clk        (clk),
        .rst        (rst),
        .catch      (catch),
        .score_ones (score_ones),
        .score_tens (score_tens)
    );

endmodule

`default_nettype wire
